//--- ao_periph_pkg.sv
// ==============================
// Address map, bus types and buffer depth for the always-on subsystem.
// Every access is a full 32-bit word; byte strobes are not supported.
// ==============================
`default_nettype none

package ao_periph_pkg;

  // Widths
  localparam int unsigned ADDR_W     = 12;
  localparam int unsigned OFS_W      = 8;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned FAST_INTR_W = 15;

  typedef logic [ADDR_W-1:0]       reg_addr_t;
  typedef logic [OFS_W-1:0]        reg_ofs_t;
  typedef logic [ADDR_W-OFS_W-1:0] periph_sel_t;
  typedef logic [DATA_W-1:0]       reg_data_t;
  typedef logic [FAST_INTR_W-1:0]  fast_intr_t;

  // Request buffer, also the credit count after reset
  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);

  typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
  typedef logic [FIFO_PTR_W:0]   fifo_cnt_t;

  // Peripheral select values in address bits 11 to 8
  localparam int unsigned PERIPH_SOC_CTRL  = 0;
  localparam int unsigned PERIPH_TIMER     = 1;
  localparam int unsigned PERIPH_FAST_INTR = 2;
  localparam int unsigned NUM_PERIPH       = 3;

  // SoC control offsets
  localparam reg_ofs_t SOC_EXIT_VALID_OFS = 8'h00;
  localparam reg_ofs_t SOC_EXIT_VALUE_OFS = 8'h04;
  localparam reg_ofs_t SOC_BOOT_SEL_OFS   = 8'h08;

  // Timer offsets
  localparam reg_ofs_t TMR_CTRL_OFS    = 8'h00;
  localparam reg_ofs_t TMR_COUNT_OFS   = 8'h04;
  localparam reg_ofs_t TMR_COMPARE_OFS = 8'h08;
  localparam reg_ofs_t TMR_STATUS_OFS  = 8'h0C;

  // Fast interrupt controller offsets
  localparam reg_ofs_t FI_PENDING_OFS = 8'h00;
  localparam reg_ofs_t FI_CLEAR_OFS   = 8'h04;

  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    reg_data_t wdata;
  } bus_req_t;

  typedef struct packed {
    reg_data_t rdata;
    logic      err;
  } bus_rsp_t;

  // Word returned by each peripheral, zero for writes
  typedef reg_data_t periph_rsp_t;

endpackage

`default_nettype wire

//--- ao_bus_fifo.sv
// ==============================
// Credit-based request buffer. The master may only push while it holds
// a credit; one credit is returned in the cycle each entry is popped.
// ==============================
`timescale 1ns/1ns
`default_nettype none

module ao_bus_fifo (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    req_valid_i,
  input  ao_periph_pkg::bus_req_t req_i,
  input  logic                    head_ready_i,
  output logic                    credit_o,
  output logic                    head_valid_o,
  output ao_periph_pkg::bus_req_t head_o
);
  import ao_periph_pkg::*;

  bus_req_t  mem_q [FIFO_DEPTH];
  fifo_ptr_t wr_ptr_q;
  fifo_ptr_t rd_ptr_q;
  fifo_cnt_t count_q;
  logic      push;
  logic      pop;
  logic      full;

  assign push = req_valid_i;
  assign pop  = head_valid_o && head_ready_i;
  assign full = (count_q == fifo_cnt_t'(FIFO_DEPTH));

  assign head_valid_o = (count_q != '0);
  assign head_o       = mem_q[rd_ptr_q];

  // One credit back per released entry
  assign credit_o = pop;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= req_i;
    end
  end

  // Depth is a power of two, so pointers wrap on their own
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Master spent a credit it did not hold
  a_no_push_when_full: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) req_valid_i |-> !full
  );

endmodule

`default_nettype wire

//--- ao_reg_decode.sv
// ==============================
// Routes each request by address bits 11 to 8, never stalls.
// Unmapped selects answer with an error and zero read data.
// ==============================
`timescale 1ns/1ns
`default_nettype none

module ao_reg_decode (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  req_valid_i,
  input  ao_periph_pkg::bus_req_t               req_i,
  input  ao_periph_pkg::periph_rsp_t            soc_rsp_i,
  input  ao_periph_pkg::periph_rsp_t            tmr_rsp_i,
  input  ao_periph_pkg::periph_rsp_t            fi_rsp_i,
  output logic                                  req_ready_o,
  output logic [ao_periph_pkg::NUM_PERIPH-1:0]  periph_valid_o,
  output ao_periph_pkg::bus_req_t               periph_req_o,
  output logic                                  rsp_valid_o,
  output ao_periph_pkg::bus_rsp_t               rsp_o
);
  import ao_periph_pkg::*;

  periph_sel_t           sel;
  periph_sel_t           sel_q;
  logic [NUM_PERIPH-1:0] hit;
  logic                  err_q;
  logic                  rsp_valid_q;
  reg_data_t             rdata;

  assign sel = req_i.addr[ADDR_W-1:OFS_W];

  assign hit[PERIPH_SOC_CTRL]  = (sel == periph_sel_t'(PERIPH_SOC_CTRL));
  assign hit[PERIPH_TIMER]     = (sel == periph_sel_t'(PERIPH_TIMER));
  assign hit[PERIPH_FAST_INTR] = (sel == periph_sel_t'(PERIPH_FAST_INTR));

  assign req_ready_o    = 1'b1;
  assign periph_valid_o = req_valid_i ? hit : '0;
  assign periph_req_o   = req_i;

  // Remember who answers next cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
      err_q       <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid_i;
      err_q       <= req_valid_i && (hit == '0);
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      sel_q <= sel;
    end
  end

  always_comb begin
    case (sel_q)
      periph_sel_t'(PERIPH_SOC_CTRL):  rdata = soc_rsp_i;
      periph_sel_t'(PERIPH_TIMER):     rdata = tmr_rsp_i;
      periph_sel_t'(PERIPH_FAST_INTR): rdata = fi_rsp_i;
      default:                         rdata = '0;
    endcase
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o.rdata = err_q ? '0 : rdata;
  assign rsp_o.err   = err_q;

  a_valid_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) $onehot0(periph_valid_o)
  );

endmodule

`default_nettype wire

//--- soc_ctrl_regs.sv
// ==============================
// Exit flag is sticky until reset.
// Boot select is read live from the pin.
// ==============================
`timescale 1ns/1ns
`default_nettype none

module soc_ctrl_regs (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       valid_i,
  input  ao_periph_pkg::bus_req_t    req_i,
  input  logic                       boot_select_i,
  output ao_periph_pkg::periph_rsp_t rsp_o,
  output logic                       exit_valid_o,
  output ao_periph_pkg::reg_data_t   exit_value_o
);
  import ao_periph_pkg::*;

  reg_ofs_t    ofs;
  logic        wr;
  logic        exit_valid_q;
  reg_data_t   exit_value_q;
  reg_data_t   rdata;
  periph_rsp_t rsp_q;

  assign ofs = req_i.addr[OFS_W-1:0];
  assign wr  = valid_i && req_i.we;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else begin
      if (wr && (ofs == SOC_EXIT_VALID_OFS) && req_i.wdata[0]) begin
        exit_valid_q <= 1'b1;
      end
      if (wr && (ofs == SOC_EXIT_VALUE_OFS)) begin
        exit_value_q <= req_i.wdata;
      end
    end
  end

  always_comb begin
    case (ofs)
      SOC_EXIT_VALID_OFS: rdata = reg_data_t'(exit_valid_q);
      SOC_EXIT_VALUE_OFS: rdata = exit_value_q;
      SOC_BOOT_SEL_OFS:   rdata = reg_data_t'(boot_select_i);
      default:            rdata = '0;
    endcase
  end

  // Writes answer with zero
  always_ff @(posedge clk_i) begin
    rsp_q <= (valid_i && !req_i.we) ? rdata : '0;
  end

  assign rsp_o        = rsp_q;
  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

`default_nettype wire

//--- ao_timer.sv
// ==============================
// Free-running compare timer, CTRL bit 0 enables counting.
// STATUS bit 0 is write-one-to-clear; a new match wins over the clear.
// ==============================
`timescale 1ns/1ns
`default_nettype none

module ao_timer (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       valid_i,
  input  ao_periph_pkg::bus_req_t    req_i,
  output ao_periph_pkg::periph_rsp_t rsp_o,
  output logic                       timer_intr_o
);
  import ao_periph_pkg::*;

  reg_ofs_t    ofs;
  logic        wr;
  logic        enable_q;
  reg_data_t   count_q;
  reg_data_t   compare_q;
  logic        status_q;
  logic        match;
  reg_data_t   rdata;
  periph_rsp_t rsp_q;

  assign ofs   = req_i.addr[OFS_W-1:0];
  assign wr    = valid_i && req_i.we;
  assign match = enable_q && (count_q >= compare_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      enable_q  <= 1'b0;
      count_q   <= '0;
      compare_q <= '0;
      status_q  <= 1'b0;
    end else begin
      if (wr && (ofs == TMR_CTRL_OFS)) begin
        enable_q <= req_i.wdata[0];
      end
      // Software write overrides the increment
      if (wr && (ofs == TMR_COUNT_OFS)) begin
        count_q <= req_i.wdata;
      end else if (enable_q) begin
        count_q <= count_q + 1'b1;
      end
      if (wr && (ofs == TMR_COMPARE_OFS)) begin
        compare_q <= req_i.wdata;
      end
      if (match) begin
        status_q <= 1'b1;
      end else if (wr && (ofs == TMR_STATUS_OFS) && req_i.wdata[0]) begin
        status_q <= 1'b0;
      end
    end
  end

  always_comb begin
    case (ofs)
      TMR_CTRL_OFS:    rdata = reg_data_t'(enable_q);
      TMR_COUNT_OFS:   rdata = count_q;
      TMR_COMPARE_OFS: rdata = compare_q;
      TMR_STATUS_OFS:  rdata = reg_data_t'(status_q);
      default:         rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    rsp_q <= (valid_i && !req_i.we) ? rdata : '0;
  end

  assign rsp_o        = rsp_q;
  assign timer_intr_o = status_q;

endmodule

`default_nettype wire

//--- fast_intr_ctrl.sv
// ==============================
// Latches 15 level inputs until cleared by mask.
// A line still high keeps its bit set.
// ==============================
`timescale 1ns/1ns
`default_nettype none

module fast_intr_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       valid_i,
  input  ao_periph_pkg::bus_req_t    req_i,
  input  ao_periph_pkg::fast_intr_t  fast_intr_i,
  output ao_periph_pkg::periph_rsp_t rsp_o,
  output ao_periph_pkg::fast_intr_t  fast_intr_o
);
  import ao_periph_pkg::*;

  reg_ofs_t    ofs;
  fast_intr_t  clr_mask;
  fast_intr_t  pending_q;
  periph_rsp_t rsp_q;

  assign ofs = req_i.addr[OFS_W-1:0];

  assign clr_mask = (valid_i && req_i.we && (ofs == FI_CLEAR_OFS)) ?
                    req_i.wdata[FAST_INTR_W-1:0] : '0;

  // Set has priority over clear
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= fast_intr_i | (pending_q & ~clr_mask);
    end
  end

  // Clear register reads back zero
  always_ff @(posedge clk_i) begin
    if (valid_i && !req_i.we && (ofs == FI_PENDING_OFS)) begin
      rsp_q <= reg_data_t'(pending_q);
    end else begin
      rsp_q <= '0;
    end
  end

  assign rsp_o       = rsp_q;
  assign fast_intr_o = pending_q;

endmodule

`default_nettype wire

//--- ao_peripheral_subsystem.sv
// ==============================
// Always-on register subsystem. Responses cannot be stalled;
// the master must accept every bus_rsp_valid_o.
// ==============================
`timescale 1ns/1ns
`default_nettype none

module ao_peripheral_subsystem (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      bus_req_valid_i,
  input  ao_periph_pkg::bus_req_t   bus_req_i,
  input  logic                      boot_select_i,
  input  ao_periph_pkg::fast_intr_t fast_intr_i,
  output logic                      bus_credit_o,
  output logic                      bus_rsp_valid_o,
  output ao_periph_pkg::bus_rsp_t   bus_rsp_o,
  output logic                      exit_valid_o,
  output ao_periph_pkg::reg_data_t  exit_value_o,
  output logic                      timer_intr_o,
  output ao_periph_pkg::fast_intr_t fast_intr_o
);
  import ao_periph_pkg::*;

  logic                  head_valid;
  bus_req_t              head;
  logic                  dec_ready;
  logic [NUM_PERIPH-1:0] periph_valid;
  bus_req_t              periph_req;
  periph_rsp_t           soc_rsp;
  periph_rsp_t           tmr_rsp;
  periph_rsp_t           fi_rsp;

  ao_bus_fifo ao_bus_fifo_i (
    .clk_i,
    .rst_n_i,
    .req_valid_i  (bus_req_valid_i),
    .req_i        (bus_req_i),
    .head_ready_i (dec_ready),
    .credit_o     (bus_credit_o),
    .head_valid_o (head_valid),
    .head_o       (head)
  );

  ao_reg_decode ao_reg_decode_i (
    .clk_i,
    .rst_n_i,
    .req_valid_i    (head_valid),
    .req_i          (head),
    .soc_rsp_i      (soc_rsp),
    .tmr_rsp_i      (tmr_rsp),
    .fi_rsp_i       (fi_rsp),
    .req_ready_o    (dec_ready),
    .periph_valid_o (periph_valid),
    .periph_req_o   (periph_req),
    .rsp_valid_o    (bus_rsp_valid_o),
    .rsp_o          (bus_rsp_o)
  );

  soc_ctrl_regs soc_ctrl_regs_i (
    .clk_i,
    .rst_n_i,
    .valid_i       (periph_valid[PERIPH_SOC_CTRL]),
    .req_i         (periph_req),
    .boot_select_i,
    .rsp_o         (soc_rsp),
    .exit_valid_o,
    .exit_value_o
  );

  ao_timer ao_timer_i (
    .clk_i,
    .rst_n_i,
    .valid_i      (periph_valid[PERIPH_TIMER]),
    .req_i        (periph_req),
    .rsp_o        (tmr_rsp),
    .timer_intr_o
  );

  fast_intr_ctrl fast_intr_ctrl_i (
    .clk_i,
    .rst_n_i,
    .valid_i     (periph_valid[PERIPH_FAST_INTR]),
    .req_i       (periph_req),
    .fast_intr_i,
    .rsp_o       (fi_rsp),
    .fast_intr_o
  );

endmodule

`default_nettype wire

//--- ao_checker.sv
// ==============================
// Expects responses in request order. Timer COUNT and STATUS reads
// are skipped; fast interrupt lines must stay low around a clear.
// ==============================
`timescale 1ns/1ns
`default_nettype none

module ao_checker (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      req_valid_i,
  input  ao_periph_pkg::bus_req_t   req_i,
  input  logic                      credit_i,
  input  logic                      rsp_valid_i,
  input  ao_periph_pkg::bus_rsp_t   rsp_i,
  input  logic                      boot_select_i,
  input  ao_periph_pkg::fast_intr_t fast_intr_i,
  input  logic                      exit_valid_i,
  input  ao_periph_pkg::reg_data_t  exit_value_i,
  input  ao_periph_pkg::fast_intr_t pending_i,
  output int                        error_count_o
);
  import ao_periph_pkg::*;

  bus_req_t   req_q [$];
  logic       exit_valid_m;
  reg_data_t  exit_value_m;
  logic       tmr_enable_m;
  reg_data_t  tmr_compare_m;
  fast_intr_t pend_m;
  fast_intr_t pend_d;
  logic       boot_d;
  int         credits;
  int         requests;
  int         credit_pulses;
  int         rsp_errors = 0;
  int         tb_errors = 0;

  assign error_count_o = rsp_errors + tb_errors;

  // Shadow model update and expected response for one request
  function automatic bus_rsp_t reference_rsp(input bus_req_t req, output logic unchecked);
    bus_rsp_t exp;
    reg_ofs_t ofs;
    exp       = '0;
    unchecked = 1'b0;
    ofs       = req.addr[7:0];
    case (req.addr[11:8])
      periph_sel_t'(PERIPH_SOC_CTRL): begin
        if (req.we && ofs == SOC_EXIT_VALID_OFS) begin
          exit_valid_m = exit_valid_m | req.wdata[0];
        end else if (req.we && ofs == SOC_EXIT_VALUE_OFS) begin
          exit_value_m = req.wdata;
        end else if (!req.we && ofs == SOC_EXIT_VALID_OFS) begin
          exp.rdata = reg_data_t'(exit_valid_m);
        end else if (!req.we && ofs == SOC_EXIT_VALUE_OFS) begin
          exp.rdata = exit_value_m;
        end else if (!req.we && ofs == SOC_BOOT_SEL_OFS) begin
          exp.rdata = reg_data_t'(boot_d);
        end
      end
      periph_sel_t'(PERIPH_TIMER): begin
        if (req.we && ofs == TMR_CTRL_OFS) begin
          tmr_enable_m = req.wdata[0];
        end else if (req.we && ofs == TMR_COMPARE_OFS) begin
          tmr_compare_m = req.wdata;
        end else if (!req.we && ofs == TMR_CTRL_OFS) begin
          exp.rdata = reg_data_t'(tmr_enable_m);
        end else if (!req.we && ofs == TMR_COMPARE_OFS) begin
          exp.rdata = tmr_compare_m;
        end else if (!req.we && (ofs == TMR_COUNT_OFS || ofs == TMR_STATUS_OFS)) begin
          unchecked = 1'b1;
        end
      end
      periph_sel_t'(PERIPH_FAST_INTR): begin
        // Clear took effect one cycle before its response
        if (req.we && ofs == FI_CLEAR_OFS) begin
          pend_m = pend_m & ~req.wdata[FAST_INTR_W-1:0];
        end else if (!req.we && ofs == FI_PENDING_OFS) begin
          exp.rdata = reg_data_t'(pend_d);
        end
      end
      default: begin
        exp.err = 1'b1;
      end
    endcase
    return exp;
  endfunction

  task automatic compare_word(input string name, input reg_data_t got, input reg_data_t exp);
    if (got !== exp) begin
      rsp_errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic note_failure(input string msg);
    tb_errors++;
    $display("%s, at %0t ns", msg, $time);
  endtask

  task automatic check_credits();
    if (credit_pulses != requests) begin
      tb_errors++;
      $display("Credit pulses (%0d) do not match accepted requests (%0d)",
               credit_pulses, requests);
    end
  endtask

  always @(posedge clk_i) begin
    bus_req_t head;
    bus_rsp_t exp;
    logic     unchecked;
    if (!rst_n_i) begin
      req_q.delete();
      exit_valid_m  = 1'b0;
      exit_value_m  = '0;
      tmr_enable_m  = 1'b0;
      tmr_compare_m = '0;
      pend_m        = '0;
      pend_d        = '0;
      boot_d        = 1'b0;
      credits       = FIFO_DEPTH;
      requests      = 0;
      credit_pulses = 0;
    end else begin
      if (rsp_valid_i && req_q.size() == 0) begin
        rsp_errors++;
        $display("Response at %0t ns with no request outstanding", $time);
      end else if (rsp_valid_i) begin
        head = req_q.pop_front();
        exp  = reference_rsp(head, unchecked);
        if (!unchecked) begin
          compare_word("bus_rsp_o.rdata", rsp_i.rdata, exp.rdata);
          compare_word("bus_rsp_o.err", reg_data_t'(rsp_i.err), reg_data_t'(exp.err));
        end
      end
      compare_word("exit_valid_o", reg_data_t'(exit_valid_i), reg_data_t'(exit_valid_m));
      compare_word("exit_value_o", exit_value_i, exit_value_m);
      compare_word("fast_intr_o", reg_data_t'(pending_i), reg_data_t'(pend_m));
      if (req_valid_i) begin
        req_q.push_back(req_i);
        requests++;
      end
      if (credit_i) begin
        credit_pulses++;
      end
      credits = credits - int'(req_valid_i) + int'(credit_i);
      if (credits < 0 || credits > int'(FIFO_DEPTH)) begin
        rsp_errors++;
        $display("Credit count out of range (%0d) at %0t ns", credits, $time);
      end
      pend_d = pend_m;
      pend_m = pend_m | fast_intr_i;
      boot_d = boot_select_i;
    end
  end

endmodule

`default_nettype wire

//--- tb_ao_peripheral_subsystem.sv
// ==============================
// Testbench for the always-on subsystem. Requests are sent only while
// a credit is held. The run is cut off after CYCLE_LIMIT clock cycles.
// ==============================
`timescale 1ns/1ns
`default_nettype none

module tb_ao_peripheral_subsystem;
  import ao_periph_pkg::*;

  // Per-test budget covers the longest test, the unmapped sweep
  localparam int NUM_TESTS   = 6;
  localparam int TEST_BUDGET = 300;
  localparam int CYCLE_LIMIT = NUM_TESTS * TEST_BUDGET + 200;

  logic        clk;
  logic        rst_n;
  logic        req_valid;
  bus_req_t    req;
  logic        boot_select;
  fast_intr_t  fast_intr;
  logic        credit;
  logic        rsp_valid;
  bus_rsp_t    rsp;
  logic        exit_valid;
  reg_data_t   exit_value;
  logic        timer_intr;
  fast_intr_t  fast_intr_out;
  int          error_count;
  int          spent = 0;
  int          returned = 0;
  int          rsp_seen = 0;
  int          cycles = 0;
  int          tests_done = 0;
  int          err_mark = 0;
  logic [31:0] lcg_state = 32'h637b0506;

  ao_peripheral_subsystem dut_i (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .bus_req_valid_i (req_valid),
    .bus_req_i       (req),
    .boot_select_i   (boot_select),
    .fast_intr_i     (fast_intr),
    .bus_credit_o    (credit),
    .bus_rsp_valid_o (rsp_valid),
    .bus_rsp_o       (rsp),
    .exit_valid_o    (exit_valid),
    .exit_value_o    (exit_value),
    .timer_intr_o    (timer_intr),
    .fast_intr_o     (fast_intr_out)
  );

  ao_checker chk_i (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .req_valid_i   (req_valid),
    .req_i         (req),
    .credit_i      (credit),
    .rsp_valid_i   (rsp_valid),
    .rsp_i         (rsp),
    .boot_select_i (boot_select),
    .fast_intr_i   (fast_intr),
    .exit_valid_i  (exit_valid),
    .exit_value_i  (exit_value),
    .pending_i     (fast_intr_out),
    .error_count_o (error_count)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (credit) begin
      returned <= returned + 1;
    end
    if (rsp_valid) begin
      rsp_seen <= rsp_seen + 1;
    end
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Result: FAILED");
      $finish;
    end
  end

  function automatic reg_data_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Spends one credit, holds valid for one cycle
  task automatic issue(input logic we, input int sel, input reg_ofs_t ofs,
                       input reg_data_t wdata);
    while (int'(FIFO_DEPTH) - spent + returned <= 0) begin
      @(negedge clk);
    end
    req_valid = 1'b1;
    req.we    = we;
    req.addr  = {periph_sel_t'(sel), ofs};
    req.wdata = we ? wdata : '0;
    spent++;
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic wait_idle();
    while (rsp_seen != spent) begin
      @(negedge clk);
    end
  endtask

  task automatic finish_test(input string name);
    wait_idle();
    tests_done++;
    if (error_count == err_mark) begin
      $display("Test %0d %s: ok", tests_done, name);
    end else begin
      $display("Test %0d %s: errors", tests_done, name);
    end
    err_mark = error_count;
  endtask

  initial begin
    reg_data_t word;
    reg_ofs_t  sweep_ofs;
    int        wait_cycles;
    rst_n       = 1'b0;
    req_valid   = 1'b0;
    req         = '0;
    boot_select = 1'b0;
    fast_intr   = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    word = next_rand();
    issue(1'b1, PERIPH_SOC_CTRL, SOC_EXIT_VALUE_OFS, word);
    issue(1'b0, PERIPH_SOC_CTRL, SOC_EXIT_VALUE_OFS, '0);
    issue(1'b1, PERIPH_SOC_CTRL, SOC_EXIT_VALID_OFS, 32'h1);
    issue(1'b0, PERIPH_SOC_CTRL, SOC_EXIT_VALID_OFS, '0);
    finish_test("exit registers");

    issue(1'b0, PERIPH_SOC_CTRL, SOC_BOOT_SEL_OFS, '0);
    wait_idle();
    boot_select = 1'b1;
    @(negedge clk);
    issue(1'b0, PERIPH_SOC_CTRL, SOC_BOOT_SEL_OFS, '0);
    finish_test("boot select");

    // Unmapped writes aim at offsets of writable mapped registers
    for (int sel = 3; sel < 16; sel++) begin
      sweep_ofs = (sel % 2 == 0) ? SOC_EXIT_VALUE_OFS : TMR_COMPARE_OFS;
      issue(1'b1, sel, sweep_ofs, next_rand());
      issue(1'b0, sel, sweep_ofs, '0);
    end
    // Mapped registers must be untouched
    issue(1'b0, PERIPH_SOC_CTRL, SOC_EXIT_VALUE_OFS, '0);
    issue(1'b0, PERIPH_SOC_CTRL, SOC_EXIT_VALID_OFS, '0);
    issue(1'b0, PERIPH_TIMER, TMR_COMPARE_OFS, '0);
    issue(1'b0, PERIPH_FAST_INTR, FI_PENDING_OFS, '0);
    finish_test("unmapped selects");

    word = next_rand();
    fast_intr = word[FAST_INTR_W-1:0];
    @(negedge clk);
    fast_intr = '0;
    repeat (2) @(negedge clk);
    issue(1'b0, PERIPH_FAST_INTR, FI_PENDING_OFS, '0);
    issue(1'b1, PERIPH_FAST_INTR, FI_CLEAR_OFS, next_rand());
    issue(1'b0, PERIPH_FAST_INTR, FI_PENDING_OFS, '0);
    issue(1'b1, PERIPH_FAST_INTR, FI_CLEAR_OFS, 32'h7fff);
    issue(1'b0, PERIPH_FAST_INTR, FI_PENDING_OFS, '0);
    finish_test("fast interrupts");

    issue(1'b1, PERIPH_TIMER, TMR_COMPARE_OFS, 32'd20);
    issue(1'b1, PERIPH_TIMER, TMR_COUNT_OFS, '0);
    issue(1'b1, PERIPH_TIMER, TMR_CTRL_OFS, 32'h1);
    wait_idle();
    wait_cycles = 0;
    while (!timer_intr && wait_cycles < 40) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (!timer_intr) begin
      chk_i.note_failure("Timer interrupt did not rise within 40 cycles");
    end
    issue(1'b1, PERIPH_TIMER, TMR_CTRL_OFS, '0);
    issue(1'b1, PERIPH_TIMER, TMR_STATUS_OFS, 32'h1);
    issue(1'b0, PERIPH_TIMER, TMR_CTRL_OFS, '0);
    wait_idle();
    if (timer_intr) begin
      chk_i.note_failure("Timer interrupt still high after the status clear");
    end
    finish_test("compare timer");

    // Four back-to-back writes followed by four reads
    for (int i = 0; i < 8; i++) begin
      issue(i < 4, (i % 2 == 0) ? PERIPH_SOC_CTRL : PERIPH_TIMER,
            (i % 2 == 0) ? SOC_EXIT_VALUE_OFS : TMR_COMPARE_OFS, next_rand());
    end
    wait_idle();
    chk_i.check_credits();
    finish_test("burst");

    $display("Tests run: %0d, errors: %0d", tests_done, error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
ao_periph_pkg.sv
ao_bus_fifo.sv
ao_reg_decode.sv
soc_ctrl_regs.sv
ao_timer.sv
fast_intr_ctrl.sv
ao_peripheral_subsystem.sv
ao_checker.sv
tb_ao_peripheral_subsystem.sv

//--- run.sh
#!/bin/sh
# Build and run with Verilator, then scan the log for a failure
rm -f sim.log
verilator --binary --timing --assert --top-module tb_ao_peripheral_subsystem -f all.f \
  && ./obj_dir/Vtb_ao_peripheral_subsystem > sim.log 2>&1 \
  && cat sim.log \
  && ! grep -q "Result: FAILED" sim.log \
  || { cat sim.log 2>/dev/null; echo "Simulation run failed"; exit 1; }
